//--- build.f
rtl/gprPkg.sv
rtl/stageWriteIf.sv
rtl/gprBanks.sv
rtl/sprFile.sv
rtl/operandFetch.sv
rtl/regFileTop.sv
sim/regFileTop_properties.sv
sim/regFileChecker.sv
sim/regFileTb.sv

//--- rtl/gprBanks.sv
/*
 General register storage with one bank per write lane and a live-value table
 that tracks which bank holds the newest copy. Four combinational reads.
*/
`timescale 1ns/1ps

module gprBanks import gprPkg::*;
#(
	parameter int dataWidth = gprPkg::dataWidth
)
(
	input logic clock,
	input logic rstN,
	input logic writeEn,	// low under hold or ex3 flush
	stageWriteIf.sink wb,	// ex3 results
	input gprIndexT rdIdS,
	input gprIndexT rdIdT,
	input gprIndexT rdIdU,
	input gprIndexT rdIdV,
	output logic [dataWidth-1:0] rdValS,
	output logic [dataWidth-1:0] rdValT,
	output logic [dataWidth-1:0] rdValU,
	output logic [dataWidth-1:0] rdValV
);

	logic [dataWidth-1:0] bankA [numGprs];	// written by lane A only
	logic [dataWidth-1:0] bankB [numGprs];	// written by lane B only
	logic [numGprs-1:0] liveB;	// set means bank B is newest

	gprIndexT wrIdxA;
	gprIndexT wrIdxB;
	logic wrA;
	logic wrB;

	assign wrIdxA = wb.idA[4:0];
	assign wrIdxB = wb.idB[4:0];

	// special and pseudo ids never land in the banks
	assign wrA = writeEn && !wb.idA[5];
	assign wrB = writeEn && !wb.idB[5];

	// bank contents
	always_ff @(posedge clock)
	begin
		if (wrA)
		begin
			bankA[wrIdxA] <= wb.valA;
		end
		if (wrB)
		begin
			bankB[wrIdxB] <= wb.valB;
		end
	end

	// live-value table
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			liveB <= '0;	// everything starts out in bank A
		end
		else
		begin
			if (wrA)
			begin
				liveB[wrIdxA] <= 1'b0;
			end
			// lane B last so it wins a same-register collision
			if (wrB)
			begin
				liveB[wrIdxB] <= 1'b1;
			end
		end
	end

	// pick the bank the table points at
	function automatic logic [dataWidth-1:0] readLive(input gprIndexT idx);
		return liveB[idx] ? bankB[idx] : bankA[idx];
	endfunction

	always_comb
	begin
		rdValS = readLive(rdIdS);	// lane A Rs port
		rdValT = readLive(rdIdT);	// lane A Rt port
		rdValU = readLive(rdIdU);	// lane B Ru port
		rdValV = readLive(rdIdV);	// lane B Rv port
	end

endmodule

//--- rtl/gprPkg.sv
/*
 Shared types and constants for the two-lane register read/write block.
 Every RTL file pulls these in with a wildcard import in its header.
*/
package gprPkg;

	// widths of the stored data and the lane immediates
	parameter int dataWidth = 64;
	parameter int numGprs = 32;
	parameter int immWidth = 33;	// bit 32 is the sign

	// 6-bit register id as seen on the read and write ports
	// top bit set means special or pseudo register, never banked
	typedef logic [5:0] regIdT;

	// index into the banks, the low five bits of a general id
	typedef logic [4:0] gprIndexT;

	// lane immediate from decode
	typedef logic [immWidth-1:0] immT;

	// special register ids
	localparam regIdT idDlr = 6'h20;	// data low register
	localparam regIdT idSp = 6'h21;	// stack pointer

	// pseudo sources, read only
	localparam regIdT idImm = 6'h3E;	// lane immediate, sign extended
	localparam regIdT idZzr = 6'h3F;	// constant zero

endpackage

//--- rtl/operandFetch.sv
/*
 One read port: decodes the source id into a stored register, a special
 register or a pseudo value, then overlays forwarded results from EX1..EX3.
 Instantiated once per read port, fed the immediate of its own lane.
*/
`timescale 1ns/1ps

module operandFetch import gprPkg::*;
#(
	parameter int dataWidth = gprPkg::dataWidth
)
(
	input regIdT rdId,	// source id for this port
	input immT imm,	// this lane's immediate
	input logic [dataWidth-1:0] gprVal,	// raw bank read for rdId
	input logic [dataWidth-1:0] dlrVal,
	input logic [dataWidth-1:0] spVal,
	stageWriteIf.sink ex1,
	stageWriteIf.sink ex2,
	stageWriteIf.sink ex3,
	output logic [dataWidth-1:0] operand
);

	logic [dataWidth-1:0] immExt;
	logic [dataWidth-1:0] baseVal;
	logic fwdOk;	// id may be replaced by an in-flight result

	// 33-bit immediate, sign bit is 32
	assign immExt = {{(dataWidth-32){imm[32]}}, imm[31:0]};

	// source decode
	always_comb
	begin
		fwdOk = 1'b1;
		case (rdId)
			idDlr:
			begin
				baseVal = dlrVal;
			end
			idSp:
			begin
				baseVal = spVal;
			end
			idImm:
			begin
				baseVal = immExt;
				fwdOk = 1'b0;	// pseudo, never forwarded
			end
			idZzr:
			begin
				baseVal = '0;
				fwdOk = 1'b0;
			end
			default:
			begin
				if (!rdId[5])
				begin
					baseVal = gprVal;	// plain general register
				end
				else
				begin
					baseVal = '0;	// unsupported special id
					fwdOk = 1'b0;
				end
			end
		endcase
	end

	// forwarding, oldest stage first so younger stages overwrite
	// lane A applied after lane B within a stage
	always_comb
	begin
		operand = baseVal;
		if (fwdOk)
		begin
			// ex3 still forwards under flush
			if (ex3.idB == rdId)
				operand = ex3.valB;
			if (ex3.idA == rdId)
				operand = ex3.valA;

			if (ex2.idB == rdId)
				operand = ex2.valB;
			if (ex2.idA == rdId)
				operand = ex2.valA;

			if (ex1.idB == rdId)
				operand = ex1.valB;
			if (ex1.idA == rdId)
				operand = ex1.valA;	// highest priority
		end
	end

endmodule

//--- rtl/regFileTop.sv
/*
 Top of the register read/write block. Flat stage ports are packed into
 stage interfaces, then shared by the banks, special registers and four read ports.
*/
`timescale 1ns/1ps

module regFileTop import gprPkg::*;
#(
	parameter int dataWidth = gprPkg::dataWidth
)
(
	input logic clock,
	input logic rstN,
	input logic hold,	// freezes all state
	input logic ex3Flush,	// blocks write-back only
	input regIdT idRs,
	input regIdT idRt,
	input regIdT idRu,
	input regIdT idRv,
	output logic [dataWidth-1:0] valRs,
	output logic [dataWidth-1:0] valRt,
	output logic [dataWidth-1:0] valRu,
	output logic [dataWidth-1:0] valRv,
	input immT immA,
	input immT immB,
	input regIdT idAEx1,
	input regIdT idBEx1,
	input logic [dataWidth-1:0] valAEx1,
	input logic [dataWidth-1:0] valBEx1,
	input regIdT idAEx2,
	input regIdT idBEx2,
	input logic [dataWidth-1:0] valAEx2,
	input logic [dataWidth-1:0] valBEx2,
	input regIdT idAEx3,
	input regIdT idBEx3,
	input logic [dataWidth-1:0] valAEx3,
	input logic [dataWidth-1:0] valBEx3,
	input logic [dataWidth-1:0] spIn,
	output logic [dataWidth-1:0] dlrOut,
	output logic [dataWidth-1:0] spOut
);

	stageWriteIf #(.dataWidth(dataWidth)) ex1If ();
	stageWriteIf #(.dataWidth(dataWidth)) ex2If ();
	stageWriteIf #(.dataWidth(dataWidth)) ex3If ();	// also the write-back stage

	logic writeEn;
	gprIndexT rdIdxS;
	gprIndexT rdIdxT;
	gprIndexT rdIdxU;
	gprIndexT rdIdxV;
	logic [dataWidth-1:0] gprS;
	logic [dataWidth-1:0] gprT;
	logic [dataWidth-1:0] gprU;
	logic [dataWidth-1:0] gprV;
	logic [dataWidth-1:0] dlrVal;
	logic [dataWidth-1:0] spVal;

	assign ex1If.idA = idAEx1;
	assign ex1If.valA = valAEx1;
	assign ex1If.idB = idBEx1;
	assign ex1If.valB = valBEx1;
	assign ex2If.idA = idAEx2;
	assign ex2If.valA = valAEx2;
	assign ex2If.idB = idBEx2;
	assign ex2If.valB = valBEx2;
	assign ex3If.idA = idAEx3;
	assign ex3If.valA = valAEx3;
	assign ex3If.idB = idBEx3;
	assign ex3If.valB = valBEx3;

	assign writeEn = !hold && !ex3Flush;

	// banks only see the low five id bits
	assign rdIdxS = idRs[4:0];
	assign rdIdxT = idRt[4:0];
	assign rdIdxU = idRu[4:0];
	assign rdIdxV = idRv[4:0];

	gprBanks #(.dataWidth(dataWidth)) banks_inst
	(
		.clock(clock), .rstN(rstN), .writeEn(writeEn), .wb(ex3If),
		.rdIdS(rdIdxS), .rdIdT(rdIdxT), .rdIdU(rdIdxU), .rdIdV(rdIdxV),
		.rdValS(gprS), .rdValT(gprT), .rdValU(gprU), .rdValV(gprV)
	);

	sprFile #(.dataWidth(dataWidth)) spr_inst
	(
		.clock(clock), .rstN(rstN), .writeEn(writeEn), .wb(ex3If),
		.spIn(spIn), .dlrVal(dlrVal), .spVal(spVal)
	);

	// lane A ports
	operandFetch #(.dataWidth(dataWidth)) fetchRs_inst
	(
		.rdId(idRs), .imm(immA), .gprVal(gprS), .dlrVal(dlrVal), .spVal(spVal),
		.ex1(ex1If), .ex2(ex2If), .ex3(ex3If), .operand(valRs)
	);

	operandFetch #(.dataWidth(dataWidth)) fetchRt_inst
	(
		.rdId(idRt), .imm(immA), .gprVal(gprT), .dlrVal(dlrVal), .spVal(spVal),
		.ex1(ex1If), .ex2(ex2If), .ex3(ex3If), .operand(valRt)
	);

	// lane B ports
	operandFetch #(.dataWidth(dataWidth)) fetchRu_inst
	(
		.rdId(idRu), .imm(immB), .gprVal(gprU), .dlrVal(dlrVal), .spVal(spVal),
		.ex1(ex1If), .ex2(ex2If), .ex3(ex3If), .operand(valRu)
	);

	operandFetch #(.dataWidth(dataWidth)) fetchRv_inst
	(
		.rdId(idRv), .imm(immB), .gprVal(gprV), .dlrVal(dlrVal), .spVal(spVal),
		.ex1(ex1If), .ex2(ex2If), .ex3(ex3If), .operand(valRv)
	);

	assign dlrOut = dlrVal;
	assign spOut = spVal;

endmodule

//--- rtl/sprFile.sv
/*
 DLR and SP special registers, written from the ex3 lanes.
 DLR holds when not written; SP reloads from spIn on every enabled cycle.
*/
`timescale 1ns/1ps

module sprFile import gprPkg::*;
#(
	parameter int dataWidth = gprPkg::dataWidth
)
(
	input logic clock,
	input logic rstN,
	input logic writeEn,	// low under hold or ex3 flush
	stageWriteIf.sink wb,	// ex3 results
	input logic [dataWidth-1:0] spIn,	// external sp source
	output logic [dataWidth-1:0] dlrVal,
	output logic [dataWidth-1:0] spVal
);

	logic [dataWidth-1:0] dlrReg;
	logic [dataWidth-1:0] spReg;
	logic [dataWidth-1:0] dlrNext;
	logic [dataWidth-1:0] spNext;

	// lane B checked first, it has priority
	always_comb
	begin
		if (wb.idB == idDlr)
			dlrNext = wb.valB;
		else if (wb.idA == idDlr)
			dlrNext = wb.valA;
		else
			dlrNext = dlrReg;	// hold

		if (wb.idB == idSp)
			spNext = wb.valB;
		else if (wb.idA == idSp)
			spNext = wb.valA;
		else
			spNext = spIn;	// track external value
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			dlrReg <= '0;
			spReg <= '0;
		end
		else if (writeEn)	// both frozen under hold or flush
		begin
			dlrReg <= dlrNext;
			spReg <= spNext;
		end
	end

	assign dlrVal = dlrReg;
	assign spVal = spReg;

endmodule

//--- rtl/stageWriteIf.sv
/*
 One pipeline stage's pair of lane results, id plus value per lane.
 Driven at the top from flat ports, read by the forwarding and write-back logic.
*/
`timescale 1ns/1ps

interface stageWriteIf import gprPkg::*;
#(
	parameter int dataWidth = gprPkg::dataWidth
);

	regIdT idA;	// lane A destination id
	logic [dataWidth-1:0] valA;	// lane A result
	regIdT idB;	// lane B destination id
	logic [dataWidth-1:0] valB;	// lane B result

	// the stage owner drives everything
	modport source
	(
		output idA,
		output valA,
		output idB,
		output valB
	);

	// forwarding and write-back only look
	modport sink
	(
		input idA,
		input valA,
		input idB,
		input valB
	);

endinterface

//--- run.sh
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator.
# Exits 0 only when the testbench prints its pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f build.f --top-module regFileTb -o regFileSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

simOutput=$(./obj_dir/regFileSim)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -qF "*** TEST PASSED ***" <<< "$simOutput"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- sim/regFileChecker.sv
/*
 Reference model and comparator for the register block. Applies the write
 rules at each rising edge, then checks the read ports and DLR/SP just after.
*/
`timescale 1ns/1ps

module regFileChecker import gprPkg::*;
#(
	parameter int nameLen = 12
)
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic ex3Flush,
	input regIdT idRs, idRt, idRu, idRv,
	input logic [dataWidth-1:0] valRs, valRt, valRu, valRv,
	input immT immA, immB,
	input regIdT idAEx1, idBEx1, idAEx2, idBEx2, idAEx3, idBEx3,
	input logic [dataWidth-1:0] valAEx1, valBEx1, valAEx2, valBEx2, valAEx3, valBEx3,
	input logic [dataWidth-1:0] spIn,
	input logic [dataWidth-1:0] dlrOut, spOut,
	input logic [8*nameLen-1:0] testName,
	output int checkCount,
	output int mismatchCount
);

	logic [dataWidth-1:0] gprModel [numGprs];
	logic [numGprs-1:0] gprKnown;	// written since reset
	logic [dataWidth-1:0] dlrModel;
	logic [dataWidth-1:0] spModel;

	// rising-edge state update
	task automatic updateModel();
		if (!rstN)
		begin
			dlrModel = '0;
			spModel = '0;
			gprKnown = '0;	// bank pointers reset so old contents are unknown
		end
		else if (!hold && !ex3Flush)
		begin
			if (!idAEx3[5])
			begin
				gprModel[idAEx3[4:0]] = valAEx3;
				gprKnown[idAEx3[4:0]] = 1'b1;
			end
			if (!idBEx3[5])	// after lane A so B wins
			begin
				gprModel[idBEx3[4:0]] = valBEx3;
				gprKnown[idBEx3[4:0]] = 1'b1;
			end
			if (idBEx3 == idDlr)
				dlrModel = valBEx3;
			else if (idAEx3 == idDlr)
				dlrModel = valAEx3;
			if (idBEx3 == idSp)
				spModel = valBEx3;
			else if (idAEx3 == idSp)
				spModel = valAEx3;
			else
				spModel = spIn;
		end
	endtask

	// expected value of one read port
	function automatic logic [dataWidth-1:0] expectRead(input regIdT id, input immT imm,
		output logic known);
		known = 1'b1;
		if (id == idImm)
			return {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};	// sign bit copied upward
		if (id == idZzr)
			return '0;
		if (id[5] && id != idDlr && id != idSp)
			return '0;	// no such special
		// youngest stage first and lane A first within it
		if (idAEx1 == id)
			return valAEx1;
		if (idBEx1 == id)
			return valBEx1;
		if (idAEx2 == id)
			return valAEx2;
		if (idBEx2 == id)
			return valBEx2;
		if (idAEx3 == id)
			return valAEx3;
		if (idBEx3 == id)
			return valBEx3;
		if (id == idDlr)
			return dlrModel;
		if (id == idSp)
			return spModel;
		known = gprKnown[id[4:0]];
		return gprModel[id[4:0]];
	endfunction

	task automatic checkPort(input string portName, input logic [dataWidth-1:0] expected,
		input logic [dataWidth-1:0] actual, input logic known);
		if (known)
		begin
			checkCount++;
			if (actual !== expected)
			begin
				mismatchCount++;
				$display("mismatch %0s %0s: expected %h actual %h",
					testName, portName, expected, actual);
			end
		end
	endtask

	always @(posedge clock)
	begin
		logic [dataWidth-1:0] expected;
		logic known;
		updateModel();
		#2;	// inputs stay put until the falling edge
		if (rstN)
		begin
			expected = expectRead(idRs, immA, known);
			checkPort("valRs", expected, valRs, known);
			expected = expectRead(idRt, immA, known);
			checkPort("valRt", expected, valRt, known);
			expected = expectRead(idRu, immB, known);	// lane B immediate
			checkPort("valRu", expected, valRu, known);
			expected = expectRead(idRv, immB, known);
			checkPort("valRv", expected, valRv, known);
			checkPort("dlrOut", dlrModel, dlrOut, 1'b1);
			checkPort("spOut", spModel, spOut, 1'b1);
		end
	end

endmodule

//--- sim/regFileTb.sv
/*
 Testbench for the two-lane register read/write block. A table of rows is
 driven one per cycle on the falling edge; regFileChecker does the comparing.
*/
`timescale 1ns/1ps

module regFileTb import gprPkg::*;
();

	localparam int resetCycles = 10;
	localparam int nameLen = 12;	// chars per test name
	localparam int zzr = int'(idZzr);	// short ids for the table
	localparam int dlr = int'(idDlr);
	localparam int sp = int'(idSp);
	localparam int imm = int'(idImm);

	// one cycle of stimulus
	typedef struct packed {
		logic [8*nameLen-1:0] name;
		regIdT idRs, idRt, idRu, idRv;
		regIdT idAEx1, idBEx1, idAEx2, idBEx2, idAEx3, idBEx3;
		logic [dataWidth-1:0] valAEx1, valBEx1, valAEx2, valBEx2, valAEx3, valBEx3;
		immT immA, immB;
		logic hold, ex3Flush;
		logic [dataWidth-1:0] spIn;
	} rowT;

	logic clock;
	logic rstN;
	logic hold;
	logic ex3Flush;
	regIdT idRs, idRt, idRu, idRv;
	logic [dataWidth-1:0] valRs, valRt, valRu, valRv;
	immT immA, immB;
	regIdT idAEx1, idBEx1, idAEx2, idBEx2, idAEx3, idBEx3;
	logic [dataWidth-1:0] valAEx1, valBEx1, valAEx2, valBEx2, valAEx3, valBEx3;
	logic [dataWidth-1:0] spIn;
	logic [dataWidth-1:0] dlrOut, spOut;
	logic [8*nameLen-1:0] testName;	// current row name for error lines
	int checkCount;
	int mismatchCount;
	int cycleCount;
	int timeoutLimit;
	logic [31:0] lfsr;
	rowT rows [$];

	regFileTop regFileTop_inst (.*);

	regFileChecker #(.nameLen(nameLen)) checker_inst (.*);

	bind regFileTop regFileTop_properties props_inst
	(
		.clock(clock), .rstN(rstN), .hold(hold), .ex3Flush(ex3Flush),
		.idRs(idRs), .valRs(valRs), .idAEx3(idAEx3), .idBEx3(idBEx3),
		.spIn(spIn), .dlrOut(dlrOut), .spOut(spOut)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;	// 10 ns period
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic nextBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [dataWidth-1:0] randWord();
		logic [dataWidth-1:0] w;
		w = '0;
		for (int i = 0; i < dataWidth; i++)
			w = {w[dataWidth-2:0], nextBit()};	// one step per bit
		return w;
	endfunction

	function automatic immT randImm();
		immT v;
		v = '0;
		for (int i = 0; i < 33; i++)
			v = {v[31:0], nextBit()};
		return v;
	endfunction

	// ids from the caller and random data
	function automatic rowT makeRow(input logic [8*nameLen-1:0] name,
		input int rs, input int rt, input int ru, input int rv,
		input int a1, input int b1, input int a2, input int b2,
		input int a3, input int b3, input int holdBit, input int flushBit);
		rowT r;
		r.name = name;
		r.idRs = regIdT'(rs);
		r.idRt = regIdT'(rt);
		r.idRu = regIdT'(ru);
		r.idRv = regIdT'(rv);
		r.idAEx1 = regIdT'(a1);
		r.idBEx1 = regIdT'(b1);
		r.idAEx2 = regIdT'(a2);
		r.idBEx2 = regIdT'(b2);
		r.idAEx3 = regIdT'(a3);
		r.idBEx3 = regIdT'(b3);
		r.valAEx1 = randWord();
		r.valBEx1 = randWord();
		r.valAEx2 = randWord();
		r.valBEx2 = randWord();
		r.valAEx3 = randWord();
		r.valBEx3 = randWord();
		r.immA = randImm();
		r.immB = randImm();
		r.hold = (holdBit != 0);
		r.ex3Flush = (flushBit != 0);
		r.spIn = randWord();
		return r;
	endfunction

	task automatic addRow(input logic [8*nameLen-1:0] name,
		input int rs, input int rt, input int ru, input int rv,
		input int a1, input int b1, input int a2, input int b2,
		input int a3, input int b3, input int holdBit, input int flushBit);
		rows.push_back(makeRow(name, rs, rt, ru, rv, a1, b1, a2, b2, a3, b3,
			holdBit, flushBit));
	endtask

	task automatic applyRow(input rowT r);
		testName = r.name;
		idRs = r.idRs;
		idRt = r.idRt;
		idRu = r.idRu;
		idRv = r.idRv;
		idAEx1 = r.idAEx1;
		idBEx1 = r.idBEx1;
		idAEx2 = r.idAEx2;
		idBEx2 = r.idBEx2;
		idAEx3 = r.idAEx3;
		idBEx3 = r.idBEx3;
		valAEx1 = r.valAEx1;
		valBEx1 = r.valBEx1;
		valAEx2 = r.valAEx2;
		valBEx2 = r.valBEx2;
		valAEx3 = r.valAEx3;
		valBEx3 = r.valBEx3;
		immA = r.immA;
		immB = r.immB;
		hold = r.hold;
		ex3Flush = r.ex3Flush;
		spIn = r.spIn;
	endtask

	// columns are name, Rs Rt Ru Rv, ex1 A B, ex2 A B, ex3 A B, hold and flush
	task automatic buildTable();
		addRow("wrA r5", 5, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 5, zzr, 0, 0);
		addRow("rd r5", 5, 5, 5, 5, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		addRow("wrAB r6", 6, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 6, 6, 0, 0);
		addRow("rd r6", 6, 6, 6, 6, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		addRow("bank A7 B8", zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 7, 8, 0, 0);
		addRow("bank rd", 7, 8, 7, 8, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		addRow("bank A8", zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 8, zzr, 0, 0);
		addRow("bank rd2", 8, 7, 8, 5, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		// same id in every stage with one source peeled off per row
		addRow("fwd all", 9, 9, 9, 9, 9, 9, 9, 9, 9, 9, 0, 0);
		addRow("fwd ex1B", 9, 9, 9, 9, zzr, 9, 9, 9, 9, 9, 0, 0);
		addRow("fwd ex2", 9, 9, 9, 9, zzr, zzr, 9, 9, 9, 9, 0, 0);
		addRow("fwd ex2B", 9, 9, 9, 9, zzr, zzr, zzr, 9, 9, 9, 0, 0);
		addRow("fwd ex3", 9, 9, 9, 9, zzr, zzr, zzr, zzr, 9, 9, 0, 0);
		addRow("fwd ex3B", 9, 9, 9, 9, zzr, zzr, zzr, zzr, zzr, 9, 0, 0);
		addRow("fwd stored", 9, 9, 9, 9, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		addRow("fwd spr", dlr, sp, dlr, sp, zzr, sp, dlr, zzr, zzr, zzr, 0, 0);
		// blocked writes while forwarding stays live
		addRow("hold wr", 5, dlr, sp, 6, zzr, zzr, zzr, zzr, 5, dlr, 1, 0);
		addRow("hold rd", 5, dlr, sp, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		addRow("flush wr", 6, sp, dlr, zzr, zzr, zzr, zzr, zzr, 6, sp, 0, 1);
		addRow("flush rd", 6, sp, dlr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		addRow("flush dlr", dlr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, dlr, zzr, 0, 1);
		addRow("hold sp", sp, zzr, zzr, zzr, zzr, zzr, zzr, zzr, sp, zzr, 1, 0);
		addRow("dlr wr", dlr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, dlr, zzr, 0, 0);
		addRow("dlr both", dlr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, dlr, dlr, 0, 0);
		addRow("dlr hold", dlr, dlr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		addRow("dlr hold2", dlr, zzr, dlr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		addRow("sp track", sp, zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		addRow("sp wr", sp, zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, sp, 0, 0);
		addRow("sp both", sp, zzr, zzr, zzr, zzr, zzr, zzr, zzr, sp, sp, 0, 0);
		addRow("sp track2", sp, zzr, sp, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		// pseudo sources must not leak through stages that name them
		addRow("imm", imm, imm, imm, imm, imm, zzr, zzr, zzr, imm, zzr, 0, 0);
		addRow("imm2", imm, zzr, imm, zzr, zzr, imm, imm, zzr, zzr, zzr, 0, 0);
		addRow("zzr", zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
		addRow("other spec", 'h25, 'h30, zzr, zzr, 'h25, 'h30, zzr, zzr, 'h25, zzr, 0, 0);
		addRow("wr r0", 0, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 0, zzr, 0, 0);
		addRow("rd r0", 0, 0, 0, 0, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0);
	endtask

	// run limit counted in rising edges
	initial
	begin
		cycleCount = 0;
		@(posedge clock);
		while (cycleCount < timeoutLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout: the table did not finish within %0d cycles", timeoutLimit);
		$display("checks %0d, mismatches %0d, timeouts 1", checkCount, mismatchCount);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		lfsr = 32'h671f_e9d4;
		buildTable();
		timeoutLimit = rows.size() + resetCycles + 20;
		rstN = 1'b0;
		applyRow(makeRow("reset", zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, zzr, 0, 0));
		repeat (resetCycles) @(negedge clock);
		rstN = 1'b1;
		foreach (rows[i])
		begin
			applyRow(rows[i]);	// on the falling edge
			@(negedge clock);
		end
		$display("checks %0d, mismatches %0d, timeouts 0", checkCount, mismatchCount);
		if (mismatchCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- sim/regFileTop_properties.sv
/*
 Assertions bound into regFileTop: DLR under hold, SP tracking spIn,
 and the zero register on the Rs port.
*/
`timescale 1ns/1ps

module regFileTop_properties import gprPkg::*;
(
	input logic clock,
	input logic rstN,
	input logic hold,
	input logic ex3Flush,
	input regIdT idRs,
	input logic [dataWidth-1:0] valRs,
	input regIdT idAEx3,
	input regIdT idBEx3,
	input logic [dataWidth-1:0] spIn,
	input logic [dataWidth-1:0] dlrOut,
	input logic [dataWidth-1:0] spOut
);

	// hold freezes dlr
	dlrHeld: assert property (@(posedge clock) disable iff (!rstN)
		hold |=> $stable(dlrOut))
		else $error("DLR changed in the cycle after hold was high");

	// no lane names sp, so it reloads from spIn
	spTracks: assert property (@(posedge clock) disable iff (!rstN)
		(!hold && !ex3Flush && idAEx3 != idSp && idBEx3 != idSp)
		|=> spOut == $past(spIn))
		else $error("SP did not load the previous spIn");

	zzrZero: assert property (@(posedge clock)
		idRs == idZzr |-> valRs == '0)
		else $error("Rs read of the zero register was not zero");

endmodule
